// ==== mem_cfg_pkg.sv ====
`default_nettype none

package mem_cfg_pkg;

   // Word width is fixed; byte merge and strobes assume four bytes
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;    // One strobe per byte

   // Hit and miss counters wrap at the top
   localparam int CNT_W = 16;

   // Front-end word address, MSB selects the control space
   localparam int DEF_ADDR_W = 12;

   // Cache index width, 16 lines
   localparam int DEF_LINE_OFF_W = 4;

endpackage

`default_nettype wire

// ==== mem_types_pkg.sv ====
`default_nettype none

package mem_types_pkg;

   // Data cache FSM
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,    // Waiting for a request
      ST_RESP  = 2'd1,    // Read hit answer
      ST_MISS  = 2'd2,    // Fetching one word
      ST_WRITE = 2'd3     // Write-through in flight
   } cache_state_e;

   // AXI4-Lite master FSM
   typedef enum logic [1:0] {
      AX_IDLE  = 2'd0,
      AX_READ  = 2'd1,    // AR issued, waiting on R
      AX_WRITE = 2'd2,    // AW/W issued, waiting on B
      AX_DONE  = 2'd3     // Answer back to the cache
   } axi_state_e;

   // Control-space word offsets
   typedef enum logic [1:0] {
      CTRL_INVALIDATE = 2'd0,    // Write only
      CTRL_HITS       = 2'd1,    // Read hit counter
      CTRL_MISSES     = 2'd2     // Read miss counter
   } ctrl_reg_e;

endpackage

`default_nettype wire

// ==== cache_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Native word bus, request held until a one-cycle ready
interface cache_bus_if #(
   parameter int AW = mem_cfg_pkg::DEF_ADDR_W - 1
);

   logic                              valid;
   logic [AW-1:0]                     addr;     // Word address
   logic [mem_cfg_pkg::DATA_W-1:0]    wdata;
   logic [mem_cfg_pkg::STRB_W-1:0]    wstrb;    // Zero means read
   logic [mem_cfg_pkg::DATA_W-1:0]    rdata;    // Valid with ready
   logic                              ready;

   modport requester (
      output valid,
      output addr,
      output wdata,
      output wstrb,
      input  rdata,
      input  ready
   );

   modport responder (
      input  valid,
      input  addr,
      input  wdata,
      input  wstrb,
      output rdata,
      output ready
   );

endinterface

`default_nettype wire

// ==== cache_ctrl_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl_regs #(
   parameter int ADDR_W = mem_cfg_pkg::DEF_ADDR_W
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              valid,
   input  logic [ADDR_W-1:0]                 addr,
   input  logic [mem_cfg_pkg::DATA_W-1:0]    wdata,
   input  logic [mem_cfg_pkg::STRB_W-1:0]    wstrb,
   output logic [mem_cfg_pkg::DATA_W-1:0]    rdata,
   output logic                              ready,
   cache_bus_if.requester                    cpu,
   input  logic                              rd_hit,
   input  logic                              rd_miss,
   output logic                              inv
);

   localparam int OFF_W = ADDR_W - 1;

   logic                              sel;          // Control space
   logic                              is_wr;
   logic [OFF_W-1:0]                  off;
   logic                              ctrl_req;
   logic                              ctrl_ready;
   logic [mem_cfg_pkg::DATA_W-1:0]    ctrl_rdata;
   logic [mem_cfg_pkg::CNT_W-1:0]     hit_cnt;
   logic [mem_cfg_pkg::CNT_W-1:0]     miss_cnt;

   assign sel   = addr[ADDR_W-1];
   assign off   = addr[OFF_W-1:0];
   assign is_wr = |wstrb;
   assign ctrl_req = valid & sel & ~ctrl_ready;    // New control access only

   // Cache space goes straight through, blocked while inv pulses
   assign cpu.valid = valid & ~sel & ~inv;
   assign cpu.addr  = off;
   assign cpu.wdata = wdata;
   assign cpu.wstrb = wstrb;

   assign ready = sel ? ctrl_ready : cpu.ready;
   assign rdata = sel ? ctrl_rdata : cpu.rdata;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ctrl_ready <= 1'b0;
         inv        <= 1'b0;
         hit_cnt    <= '0;
         miss_cnt   <= '0;
      end else begin
         ctrl_ready <= ctrl_req;    // One-cycle answer
         // Only one request in flight, so the cache is idle by now
         inv <= ctrl_ready & is_wr &
                (off == OFF_W'(mem_types_pkg::CTRL_INVALIDATE));
         hit_cnt  <= hit_cnt + mem_cfg_pkg::CNT_W'(rd_hit);      // Wraps
         miss_cnt <= miss_cnt + mem_cfg_pkg::CNT_W'(rd_miss);
      end
   end

   // Register read mux
   always_ff @(posedge clk) begin
      if (ctrl_req) begin
         if (is_wr)
            ctrl_rdata <= '0;
         else if (off == OFF_W'(mem_types_pkg::CTRL_HITS))
            ctrl_rdata <= mem_cfg_pkg::DATA_W'(hit_cnt);
         else if (off == OFF_W'(mem_types_pkg::CTRL_MISSES))
            ctrl_rdata <= mem_cfg_pkg::DATA_W'(miss_cnt);
         else
            ctrl_rdata <= '0;    // Undefined offset
      end
   end

endmodule

`default_nettype wire

// ==== dcache_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_core #(
   parameter int ADDR_W     = mem_cfg_pkg::DEF_ADDR_W,
   parameter int LINE_OFF_W = mem_cfg_pkg::DEF_LINE_OFF_W
) (
   input  logic              clk,
   input  logic              rst,
   cache_bus_if.responder    cpu,
   cache_bus_if.requester    mem,
   input  logic              inv,
   output logic              rd_hit,
   output logic              rd_miss
);

   localparam int WA_W  = ADDR_W - 1;              // Cache-space word address
   localparam int TAG_W = WA_W - LINE_OFF_W;
   localparam int LINES = 1 << LINE_OFF_W;

   mem_types_pkg::cache_state_e       state;

   logic [LINES-1:0]                  line_vld;
   logic [TAG_W-1:0]                  tag_ram [LINES];
   logic [mem_cfg_pkg::DATA_W-1:0]    data_ram [LINES];

   logic [LINE_OFF_W-1:0]             idx;
   logic [TAG_W-1:0]                  tag;
   logic                              hit;
   logic                              is_wr;
   logic                              accept;
   logic                              fill;

   logic [mem_cfg_pkg::DATA_W-1:0]    rdata_q;     // Hit data
   logic                              mem_valid_q;
   logic [WA_W-1:0]                   mem_addr_q;
   logic [mem_cfg_pkg::DATA_W-1:0]    mem_wdata_q;
   logic [mem_cfg_pkg::STRB_W-1:0]    mem_wstrb_q;

   // Address split, held by the requester until ready
   assign idx = cpu.addr[LINE_OFF_W-1:0];
   assign tag = cpu.addr[WA_W-1:LINE_OFF_W];

   assign hit    = line_vld[idx] & (tag_ram[idx] == tag);
   assign is_wr  = |cpu.wstrb;
   assign accept = (state == mem_types_pkg::ST_IDLE) & ~inv & cpu.valid;
   assign fill   = (state == mem_types_pkg::ST_MISS) & mem.ready;

   // One pulse per read for the counters
   assign rd_hit  = accept & ~is_wr & hit;
   assign rd_miss = accept & ~is_wr & ~hit;

   // Miss and write answer in the same cycle as the back-end ready
   assign cpu.ready = (state == mem_types_pkg::ST_RESP) |
                      (((state == mem_types_pkg::ST_MISS) |
                        (state == mem_types_pkg::ST_WRITE)) & mem.ready);
   assign cpu.rdata = (state == mem_types_pkg::ST_MISS) ? mem.rdata : rdata_q;

   assign mem.valid = mem_valid_q;
   assign mem.addr  = mem_addr_q;
   assign mem.wdata = mem_wdata_q;
   assign mem.wstrb = mem_wstrb_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= mem_types_pkg::ST_IDLE;
         line_vld    <= '0;
         mem_valid_q <= 1'b0;
      end else begin
         case (state)
            mem_types_pkg::ST_IDLE: begin
               if (inv) begin
                  line_vld <= '0;    // Flush all lines at once
               end else if (cpu.valid) begin
                  if (is_wr) begin
                     mem_valid_q <= 1'b1;    // Always write through
                     state       <= mem_types_pkg::ST_WRITE;
                  end else if (hit) begin
                     state <= mem_types_pkg::ST_RESP;
                  end else begin
                     mem_valid_q <= 1'b1;
                     state       <= mem_types_pkg::ST_MISS;
                  end
               end
            end
            mem_types_pkg::ST_RESP:
               state <= mem_types_pkg::ST_IDLE;
            mem_types_pkg::ST_MISS: begin
               if (mem.ready) begin
                  mem_valid_q   <= 1'b0;
                  line_vld[idx] <= 1'b1;
                  state         <= mem_types_pkg::ST_IDLE;
               end
            end
            mem_types_pkg::ST_WRITE: begin
               if (mem.ready) begin
                  mem_valid_q <= 1'b0;
                  state       <= mem_types_pkg::ST_IDLE;
               end
            end
            default: state <= mem_types_pkg::ST_IDLE;
         endcase
      end
   end

   // Arrays and back-end payload
   always_ff @(posedge clk) begin
      if (accept) begin
         mem_addr_q  <= cpu.addr;
         mem_wdata_q <= cpu.wdata;
         mem_wstrb_q <= cpu.wstrb;    // Zero for a read
         rdata_q     <= data_ram[idx];
         if (is_wr && hit) begin
            for (int b = 0; b < mem_cfg_pkg::STRB_W; b++) begin
               if (cpu.wstrb[b])
                  data_ram[idx][8*b +: 8] <= cpu.wdata[8*b +: 8];    // Byte merge
            end
         end
      end
      if (fill) begin
         data_ram[idx] <= mem.rdata;
         tag_ram[idx]  <= tag;
      end
   end

endmodule

`default_nettype wire

// ==== axi_lite_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_lite_master #(
   parameter int ADDR_W = mem_cfg_pkg::DEF_ADDR_W
) (
   input  logic                              clk,
   input  logic                              rst,
   cache_bus_if.responder                    mem,
   output logic [ADDR_W:0]                   axi_awaddr,
   output logic                              axi_awvalid,
   input  logic                              axi_awready,
   output logic [mem_cfg_pkg::DATA_W-1:0]    axi_wdata,
   output logic [mem_cfg_pkg::STRB_W-1:0]    axi_wstrb,
   output logic                              axi_wvalid,
   input  logic                              axi_wready,
   input  logic [1:0]                        axi_bresp,    // Ignored
   input  logic                              axi_bvalid,
   output logic                              axi_bready,
   output logic [ADDR_W:0]                   axi_araddr,
   output logic                              axi_arvalid,
   input  logic                              axi_arready,
   input  logic [mem_cfg_pkg::DATA_W-1:0]    axi_rdata,
   input  logic [1:0]                        axi_rresp,    // Ignored
   input  logic                              axi_rvalid,
   output logic                              axi_rready
);

   mem_types_pkg::axi_state_e         state;
   logic [mem_cfg_pkg::DATA_W-1:0]    rdata_q;

   // Word to byte address; payload is held by the cache
   assign axi_awaddr = {mem.addr, 2'b00};
   assign axi_araddr = {mem.addr, 2'b00};
   assign axi_wdata  = mem.wdata;
   assign axi_wstrb  = mem.wstrb;

   // Always ready for the response while waiting
   assign axi_rready = (state == mem_types_pkg::AX_READ);
   assign axi_bready = (state == mem_types_pkg::AX_WRITE);

   assign mem.ready = (state == mem_types_pkg::AX_DONE);
   assign mem.rdata = rdata_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= mem_types_pkg::AX_IDLE;
         axi_awvalid <= 1'b0;
         axi_wvalid  <= 1'b0;
         axi_arvalid <= 1'b0;
      end else begin
         // Each channel drops on its own handshake
         if (axi_awready)
            axi_awvalid <= 1'b0;
         if (axi_wready)
            axi_wvalid <= 1'b0;
         if (axi_arready)
            axi_arvalid <= 1'b0;
         case (state)
            mem_types_pkg::AX_IDLE: begin
               if (mem.valid) begin
                  if (|mem.wstrb) begin
                     axi_awvalid <= 1'b1;
                     axi_wvalid  <= 1'b1;
                     state       <= mem_types_pkg::AX_WRITE;
                  end else begin
                     axi_arvalid <= 1'b1;
                     state       <= mem_types_pkg::AX_READ;
                  end
               end
            end
            mem_types_pkg::AX_READ:
               if (axi_rvalid) state <= mem_types_pkg::AX_DONE;
            mem_types_pkg::AX_WRITE:
               if (axi_bvalid) state <= mem_types_pkg::AX_DONE;
            default:
               state <= mem_types_pkg::AX_IDLE;    // AX_DONE, ready pulse done
         endcase
      end
   end

   // Read data capture on the R handshake
   always_ff @(posedge clk) begin
      if (axi_rready && axi_rvalid)
         rdata_q <= axi_rdata;
   end

endmodule

`default_nettype wire

// ==== ext_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module ext_mem #(
   parameter int ADDR_W     = mem_cfg_pkg::DEF_ADDR_W,
   parameter int LINE_OFF_W = mem_cfg_pkg::DEF_LINE_OFF_W
) (
   input  logic                              clk,
   input  logic                              rst,
   // Processor side
   input  logic                              valid,
   input  logic [ADDR_W-1:0]                 addr,    // MSB selects control space
   input  logic [mem_cfg_pkg::DATA_W-1:0]    wdata,
   input  logic [mem_cfg_pkg::STRB_W-1:0]    wstrb,
   output logic [mem_cfg_pkg::DATA_W-1:0]    rdata,
   output logic                              ready,
   // AXI4-Lite to external memory
   output logic [ADDR_W:0]                   axi_awaddr,
   output logic                              axi_awvalid,
   input  logic                              axi_awready,
   output logic [mem_cfg_pkg::DATA_W-1:0]    axi_wdata,
   output logic [mem_cfg_pkg::STRB_W-1:0]    axi_wstrb,
   output logic                              axi_wvalid,
   input  logic                              axi_wready,
   input  logic [1:0]                        axi_bresp,
   input  logic                              axi_bvalid,
   output logic                              axi_bready,
   output logic [ADDR_W:0]                   axi_araddr,
   output logic                              axi_arvalid,
   input  logic                              axi_arready,
   input  logic [mem_cfg_pkg::DATA_W-1:0]    axi_rdata,
   input  logic [1:0]                        axi_rresp,
   input  logic                              axi_rvalid,
   output logic                              axi_rready
);

   logic rd_hit;
   logic rd_miss;
   logic inv;

   // Both buses carry the cache-space word address
   cache_bus_if #(.AW(ADDR_W - 1)) cpu_bus ();
   cache_bus_if #(.AW(ADDR_W - 1)) mem_bus ();

   cache_ctrl_regs #(
      .ADDR_W (ADDR_W)
   ) u_ctrl (
      .clk     (clk),
      .rst     (rst),
      .valid   (valid),
      .addr    (addr),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .rdata   (rdata),
      .ready   (ready),
      .cpu     (cpu_bus.requester),
      .rd_hit  (rd_hit),
      .rd_miss (rd_miss),
      .inv     (inv)
   );

   dcache_core #(
      .ADDR_W     (ADDR_W),
      .LINE_OFF_W (LINE_OFF_W)
   ) u_dcache (
      .clk     (clk),
      .rst     (rst),
      .cpu     (cpu_bus.responder),
      .mem     (mem_bus.requester),
      .inv     (inv),
      .rd_hit  (rd_hit),
      .rd_miss (rd_miss)
   );

   axi_lite_master #(
      .ADDR_W (ADDR_W)
   ) u_axi (
      .clk         (clk),
      .rst         (rst),
      .mem         (mem_bus.responder),
      .axi_awaddr  (axi_awaddr),
      .axi_awvalid (axi_awvalid),
      .axi_awready (axi_awready),
      .axi_wdata   (axi_wdata),
      .axi_wstrb   (axi_wstrb),
      .axi_wvalid  (axi_wvalid),
      .axi_wready  (axi_wready),
      .axi_bresp   (axi_bresp),
      .axi_bvalid  (axi_bvalid),
      .axi_bready  (axi_bready),
      .axi_araddr  (axi_araddr),
      .axi_arvalid (axi_arvalid),
      .axi_arready (axi_arready),
      .axi_rdata   (axi_rdata),
      .axi_rresp   (axi_rresp),
      .axi_rvalid  (axi_rvalid),
      .axi_rready  (axi_rready)
   );

endmodule

`default_nettype wire

// ==== tb_ext_mem_tests.svh ====
`ifndef TB_EXT_MEM_TESTS_SVH
`define TB_EXT_MEM_TESTS_SVH

// One row per front-end access
string               name_q  [$];
logic [ADDR_W-1:0]   addr_q  [$];
logic [DW-1:0]       wdata_q [$];
logic [SW-1:0]       wstrb_q [$];
bit                  chk_q   [$];    // Compare rdata
logic [DW-1:0]       exp_q   [$];

task automatic add_entry(input string name, input logic [ADDR_W-1:0] a,
                         input logic [DW-1:0] wd, input logic [SW-1:0] ws,
                         input bit chk, input logic [DW-1:0] exp);
   name_q.push_back(name);
   addr_q.push_back(a);
   wdata_q.push_back(wd);
   wstrb_q.push_back(ws);
   chk_q.push_back(chk);
   exp_q.push_back(exp);
endtask

// Word at byte address a starts as a ^ A5A5_0000, 12'h8xx is control space
// A=010 line 0, B=025 and C=135 share line 5, D=3F7 line 7, E=7FF line 15
task automatic load_table();
   //         name              addr     wdata          strb  chk   expected
   add_entry("rd_a_miss",       12'h010, 32'h0000_0000, 4'h0, 1'b1, 32'hA5A5_0040);
   add_entry("rd_a_hit",        12'h010, 32'h0000_0000, 4'h0, 1'b1, 32'hA5A5_0040);
   add_entry("rd_hits_1",       12'h801, 32'h0000_0000, 4'h0, 1'b1, 32'd1);
   add_entry("rd_misses_1",     12'h802, 32'h0000_0000, 4'h0, 1'b1, 32'd1);
   add_entry("wr_a_partial",    12'h010, 32'h1122_3344, 4'h5, 1'b0, 32'h0);    // Bytes 0 and 2
   add_entry("rd_a_merged",     12'h010, 32'h0000_0000, 4'h0, 1'b1, 32'hA522_0044);
   add_entry("wr_b_uncached",   12'h025, 32'hDEAD_BEEF, 4'hF, 1'b0, 32'h0);    // No allocate
   add_entry("rd_b_fetch",      12'h025, 32'h0000_0000, 4'h0, 1'b1, 32'hDEAD_BEEF);
   add_entry("wr_d_upper",      12'h3F7, 32'h0BAD_F00D, 4'hC, 1'b0, 32'h0);
   add_entry("rd_d_fetch",      12'h3F7, 32'h0000_0000, 4'h0, 1'b1, 32'h0BAD_0FDC);
   add_entry("rd_c_evict_b",    12'h135, 32'h0000_0000, 4'h0, 1'b1, 32'hA5A5_04D4);
   add_entry("rd_b_refetch",    12'h025, 32'h0000_0000, 4'h0, 1'b1, 32'hDEAD_BEEF);
   add_entry("rd_b_hit",        12'h025, 32'h0000_0000, 4'h0, 1'b1, 32'hDEAD_BEEF);
   add_entry("rd_hits_2",       12'h801, 32'h0000_0000, 4'h0, 1'b1, 32'd3);
   add_entry("rd_misses_2",     12'h802, 32'h0000_0000, 4'h0, 1'b1, 32'd5);
   add_entry("wr_invalidate",   12'h800, 32'h0000_0000, 4'hF, 1'b0, 32'h0);
   add_entry("rd_a_after_inv",  12'h010, 32'h0000_0000, 4'h0, 1'b1, 32'hA522_0044);
   add_entry("rd_misses_3",     12'h802, 32'h0000_0000, 4'h0, 1'b1, 32'd6);
   add_entry("rd_hits_3",       12'h801, 32'h0000_0000, 4'h0, 1'b1, 32'd3);
   add_entry("rd_a_hit_again",  12'h010, 32'h0000_0000, 4'h0, 1'b1, 32'hA522_0044);
   add_entry("rd_ctrl_undef",   12'h803, 32'h0000_0000, 4'h0, 1'b1, 32'h0);    // Reads as zero
   add_entry("rd_e_miss",       12'h7FF, 32'h0000_0000, 4'h0, 1'b1, 32'hA5A5_1FFC);
   add_entry("wr_e_top_byte",   12'h7FF, 32'hCAFE_0000, 4'h8, 1'b0, 32'h0);
   add_entry("rd_e_merged",     12'h7FF, 32'h0000_0000, 4'h0, 1'b1, 32'hCAA5_1FFC);
   add_entry("rd_hits_4",       12'h801, 32'h0000_0000, 4'h0, 1'b1, 32'd5);
   add_entry("rd_misses_4",     12'h802, 32'h0000_0000, 4'h0, 1'b1, 32'd7);
endtask

// Back-to-back requests, each held until ready
task automatic apply_table();
   logic [DW-1:0] got;
   bit            bad;
   for (int i = 0; i < name_q.size(); i++) begin
      @(posedge clk);
      valid <= 1'b1;
      addr  <= addr_q[i];
      wdata <= wdata_q[i];
      wstrb <= wstrb_q[i];
      @(negedge clk);
      while (!ready)
         @(negedge clk);    // Latency varies with AXI stalls
      got = rdata;          // Mid-cycle, stable
      bad = 1'b0;
      test_cnt++;
      if (chk_q[i]) begin
         assert (got == exp_q[i]) else begin
            $display("Mismatch in %s: expected %h, actual %h", name_q[i], exp_q[i], got);
            bad = 1'b1;
         end
      end
      if (bad) begin
         err_cnt++;
      end else begin
         pass_cnt++;
         $display("test %s ok, rdata %h", name_q[i], got);
      end
   end
   @(posedge clk);
   valid <= 1'b0;
endtask

`endif

// ==== tb_ext_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ext_mem;

   localparam int ADDR_W       = mem_cfg_pkg::DEF_ADDR_W;
   localparam int DW           = mem_cfg_pkg::DATA_W;
   localparam int SW           = mem_cfg_pkg::STRB_W;
   localparam int MEM_WORDS    = 1 << (ADDR_W - 1);    // Whole cache space
   localparam int RESET_CYCLES = 3;
   localparam logic [31:0] SEED = 32'h450a;

   // Front end
   logic                 clk   = 1'b0;
   logic                 rst   = 1'b1;
   logic                 valid = 1'b0;
   logic [ADDR_W-1:0]    addr  = '0;
   logic [DW-1:0]        wdata = '0;
   logic [SW-1:0]        wstrb = '0;
   logic [DW-1:0]        rdata;
   logic                 ready;

   // AXI4-Lite, slave side driven by the memory model
   logic [ADDR_W:0]      axi_awaddr;
   logic                 axi_awvalid;
   logic                 axi_awready = 1'b0;
   logic [DW-1:0]        axi_wdata;
   logic [SW-1:0]        axi_wstrb;
   logic                 axi_wvalid;
   logic                 axi_wready  = 1'b0;
   logic [1:0]           axi_bresp   = 2'b00;    // Always OKAY
   logic                 axi_bvalid  = 1'b0;
   logic                 axi_bready;
   logic [ADDR_W:0]      axi_araddr;
   logic                 axi_arvalid;
   logic                 axi_arready = 1'b0;
   logic [DW-1:0]        axi_rdata   = '0;
   logic [1:0]           axi_rresp   = 2'b00;
   logic                 axi_rvalid  = 1'b0;
   logic                 axi_rready;

   // Memory model state
   logic [DW-1:0]        mem_words [0:MEM_WORDS-1];
   logic [31:0]          rng_state;
   logic [1:0]           dly;
   logic [1:0]           ar_wait, r_wait, aw_wait, w_wait, b_wait;
   logic                 rd_pend, aw_got, w_got;
   logic [ADDR_W-2:0]    rd_word, wr_word;
   logic [DW-1:0]        wr_data;
   logic [SW-1:0]        wr_strb;

   // Run bookkeeping
   int                   err_cnt   = 0;
   int                   pass_cnt  = 0;
   int                   test_cnt  = 0;
   int                   cycle_cnt = 0;
   int                   cycle_limit;

   `include "tb_ext_mem_tests.svh"

   ext_mem DUT (
      .clk         (clk),
      .rst         (rst),
      .valid       (valid),
      .addr        (addr),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .rdata       (rdata),
      .ready       (ready),
      .axi_awaddr  (axi_awaddr),
      .axi_awvalid (axi_awvalid),
      .axi_awready (axi_awready),
      .axi_wdata   (axi_wdata),
      .axi_wstrb   (axi_wstrb),
      .axi_wvalid  (axi_wvalid),
      .axi_wready  (axi_wready),
      .axi_bresp   (axi_bresp),
      .axi_bvalid  (axi_bvalid),
      .axi_bready  (axi_bready),
      .axi_araddr  (axi_araddr),
      .axi_arvalid (axi_arvalid),
      .axi_arready (axi_arready),
      .axi_rdata   (axi_rdata),
      .axi_rresp   (axi_rresp),
      .axi_rvalid  (axi_rvalid),
      .axi_rready  (axi_rready)
   );

   always #20 clk = ~clk;    // 40 ns period

   // LCG step, constants from the classic C library
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // Random 0..3 cycle stall
   task automatic next_delay(output logic [1:0] d);
      rng_state = lcg_next(rng_state);
      d = rng_state[17:16];
   endtask

   // AXI4-Lite slave, each channel stalls on its own
   always @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < MEM_WORDS; i++)
            mem_words[i] <= (i * 4) ^ 32'hA5A5_0000;    // Byte address XOR pattern
         rng_state = SEED;
         {axi_arready, axi_rvalid, axi_awready, axi_wready, axi_bvalid} <= '0;
         {rd_pend, aw_got, w_got} <= '0;
         {ar_wait, r_wait, aw_wait, w_wait, b_wait} <= '0;
      end else begin
         if (axi_arvalid && axi_arready) begin
            axi_arready <= 1'b0;
            rd_word     <= axi_araddr[ADDR_W:2];
            rd_pend     <= 1'b1;
            next_delay(dly);
            r_wait <= dly;
            next_delay(dly);
            ar_wait <= dly;    // Stall for the next AR
         end else if (axi_arvalid) begin
            if (ar_wait == 2'd0)
               axi_arready <= 1'b1;
            else
               ar_wait <= ar_wait - 2'd1;
         end
         if (axi_rvalid && axi_rready) begin
            axi_rvalid <= 1'b0;
         end else if (rd_pend && !axi_rvalid) begin
            if (r_wait == 2'd0) begin
               axi_rvalid <= 1'b1;
               axi_rdata  <= mem_words[rd_word];
               rd_pend    <= 1'b0;
            end else begin
               r_wait <= r_wait - 2'd1;
            end
         end
         if (axi_awvalid && axi_awready) begin
            axi_awready <= 1'b0;
            wr_word     <= axi_awaddr[ADDR_W:2];
            aw_got      <= 1'b1;
            next_delay(dly);
            aw_wait <= dly;
         end else if (axi_awvalid) begin
            if (aw_wait == 2'd0)
               axi_awready <= 1'b1;
            else
               aw_wait <= aw_wait - 2'd1;
         end
         if (axi_wvalid && axi_wready) begin
            axi_wready <= 1'b0;
            wr_data    <= axi_wdata;
            wr_strb    <= axi_wstrb;
            w_got      <= 1'b1;
            next_delay(dly);
            w_wait <= dly;
         end else if (axi_wvalid) begin
            if (w_wait == 2'd0)
               axi_wready <= 1'b1;
            else
               w_wait <= w_wait - 2'd1;
         end
         // B only once address and data are both in
         if (axi_bvalid && axi_bready) begin
            axi_bvalid <= 1'b0;
         end else if (aw_got && w_got && !axi_bvalid) begin
            if (b_wait == 2'd0) begin
               for (int b = 0; b < SW; b++)
                  if (wr_strb[b])
                     mem_words[wr_word][8*b +: 8] <= wr_data[8*b +: 8];
               axi_bvalid <= 1'b1;
               aw_got     <= 1'b0;
               w_got      <= 1'b0;
               next_delay(dly);
               b_wait <= dly;
            end else begin
               b_wait <= b_wait - 2'd1;
            end
         end
      end
   end

   // Hang guard
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Run timed out after %0d cycles, ready never came back", cycle_cnt);
         $display("Finished with errors");
         $finish;
      end
   end

   initial begin
      load_table();
      cycle_limit = 60 * name_q.size() + RESET_CYCLES + 2;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      test_cnt++;
      assert (!ready && !axi_awvalid && !axi_wvalid && !axi_arvalid &&
              !axi_bready && !axi_rready) else begin
         $display("Outputs not all low right after reset");
         err_cnt++;
      end
      if (err_cnt == 0) begin
         pass_cnt++;
         $display("test reset_outputs ok");
      end
      apply_table();
      $display("Tests run %0d, passed %0d, failed %0d", test_cnt, pass_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
mem_cfg_pkg.sv
mem_types_pkg.sv
cache_bus_if.sv
cache_ctrl_regs.sv
dcache_core.sv
axi_lite_master.sv
ext_mem.sv
tb_ext_mem.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_ext_mem -f project.f &&
./obj_dir/Vtb_ext_mem | tee /dev/stderr | grep -q "Finished with no errors" ||
{ echo "Simulation failed" >&2; exit 1; }
